// ==== hdl/cic_dsp_pkg.sv ====
// Arithmetic constants for the CIC decimator datapath.
// The accumulator is sized for the largest ratio (64), so all
// integrators and combs wrap in two's complement without loss.
// GROWTH_MAX must track the largest ratio held in cic_ctl_pkg.

package cic_dsp_pkg;

    // integrator and comb stage count
    localparam int STAGES = 4;

    // sample widths at the filter boundary
    localparam int IN_WIDTH  = 16;
    localparam int OUT_WIDTH = 16;

    // four stages times log2 of the largest ratio (64)
    localparam int GROWTH_MAX = 24;

    // full accumulator width shared by every stage
    localparam int ACC_WIDTH = IN_WIDTH + GROWTH_MAX;

endpackage

// ==== hdl/cic_ctl_pkg.sv ====
// Constants for ratio encoding and rate control.
// Ratios are powers of two, carried as log2 in a 3-bit field;
// codes above LOG2_MAX_DECIM are clamped when loaded.

package cic_ctl_pkg;

    // width of the log2 ratio field on the config port
    localparam int LOG2_WIDTH = 3;

    // largest supported ratio as log2, i.e. decimate by 64
    localparam logic [LOG2_WIDTH-1:0] LOG2_MAX_DECIM = 3'd6;

    // sample counter covers 0 .. 63
    localparam int COUNT_WIDTH = 6;

endpackage

// ==== hdl/cic_rate_control.sv ====
// Config port and rate control for the CIC decimator.
// Four-phase req/ack: a value is taken while req is high and ack is
// low, and ack drops the edge after req drops. Each load clears the
// sample counter and pulses flush for one cycle.
// Ratio codes above 6 are clamped to 6. After reset the ratio is 1.

`timescale 1ns/1ps

module cic_rate_control (
    input  logic                               clock,
    input  logic                               rst_n,
    input  logic                               cfg_req,
    input  logic [cic_ctl_pkg::LOG2_WIDTH-1:0] cfg_log2_decim,
    input  logic                               pre_strobe,
    output logic                               cfg_ack,
    output logic [cic_ctl_pkg::LOG2_WIDTH-1:0] log2_decim,
    output logic                               flush,
    output logic                               dec_strobe
);

    logic                                  cfg_load;
    logic [cic_ctl_pkg::LOG2_WIDTH-1:0]    cfg_clamped;
    logic [cic_ctl_pkg::COUNT_WIDTH-1:0]   sample_no;
    logic [cic_ctl_pkg::COUNT_WIDTH-1:0]   last_count;

    assign cfg_load = cfg_req && !cfg_ack;

    assign cfg_clamped = (cfg_log2_decim > cic_ctl_pkg::LOG2_MAX_DECIM)
                       ? cic_ctl_pkg::LOG2_MAX_DECIM : cfg_log2_decim;

    // ratio minus one, as a low-bit mask of the counter
    assign last_count = ~({cic_ctl_pkg::COUNT_WIDTH{1'b1}} << log2_decim);

    // handshake and ratio register
    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            cfg_ack    <= 1'b0;
            log2_decim <= '0;
            flush      <= 1'b0;
        end
        else
        begin
            flush <= cfg_load;
            if (cfg_load)
            begin
                cfg_ack    <= 1'b1;
                log2_decim <= cfg_clamped;
            end
            else if (!cfg_req)
            begin
                cfg_ack <= 1'b0;
            end
        end
    end

    // sample counter, dec_strobe follows the last sample of a group
    always_ff @(posedge clock)
    begin
        if (!rst_n || cfg_load)
        begin
            sample_no  <= '0;
            dec_strobe <= 1'b0;
        end
        else if (pre_strobe)
        begin
            if (sample_no == last_count)
            begin
                sample_no  <= '0;
                dec_strobe <= 1'b1;
            end
            else
            begin
                sample_no  <= sample_no + 1'b1;
                dec_strobe <= 1'b0;
            end
        end
        else
        begin
            dec_strobe <= 1'b0;
        end
    end

    // the master withdraws a request only once ack has answered it
    a_req_held_for_ack: assert property (@(posedge clock) disable iff (!rst_n)
        $fell(cfg_req) |-> cfg_ack);

    // the master keeps samples away from a load, so none meets the flush
    a_no_sample_on_flush: assert property (@(posedge clock) disable iff (!rst_n)
        flush |-> !pre_strobe);

endmodule

// ==== hdl/cic_prescale.sv ====
// Input register with growth-normalizing left shift.
// The shift is STAGES * (6 - log2 ratio), which puts the full-scale
// DC gain of every ratio at the top of the 40-bit accumulator.
// pre_data holds its value between strobes; the bypass path and the
// first integrator both read it.

`timescale 1ns/1ps

module cic_prescale (
    input  logic                                     clock,
    input  logic                                     rst_n,
    input  logic                                     in_strobe,
    input  logic signed [cic_dsp_pkg::IN_WIDTH-1:0]  in_data,
    input  logic [cic_ctl_pkg::LOG2_WIDTH-1:0]       log2_decim,
    output logic                                     pre_strobe,
    output logic signed [cic_dsp_pkg::ACC_WIDTH-1:0] pre_data
);

    logic signed [cic_dsp_pkg::ACC_WIDTH-1:0] ext_data;

    // sign extension to the accumulator width
    assign ext_data = in_data;

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            pre_strobe <= 1'b0;
        end
        else
        begin
            pre_strobe <= in_strobe;
        end
    end

    // payload register, loaded only with a sample
    always_ff @(posedge clock)
    begin
        if (in_strobe)
        begin
            pre_data <= ext_data <<< (cic_dsp_pkg::STAGES *
                        (cic_ctl_pkg::LOG2_MAX_DECIM - log2_decim));
        end
    end

    // back-to-back samples would break the one-cycle bypass window
    a_strobe_spacing: assert property (@(posedge clock) disable iff (!rst_n)
        in_strobe |=> !in_strobe);

endmodule

// ==== hdl/cic_integrator_chain.sv ====
// Four cascaded integrators at the input rate.
// All stages update in the same cycle: each one adds the new value
// of the stage before it. Sums wrap in two's complement, which the
// comb chain undoes as long as the final result fits the width.

`timescale 1ns/1ps

module cic_integrator_chain (
    input  logic                                     clock,
    input  logic                                     rst_n,
    input  logic                                     flush,
    input  logic                                     pre_strobe,
    input  logic signed [cic_dsp_pkg::ACC_WIDTH-1:0] pre_data,
    output logic signed [cic_dsp_pkg::ACC_WIDTH-1:0] int_data
);

    logic signed [cic_dsp_pkg::ACC_WIDTH-1:0] acc      [cic_dsp_pkg::STAGES];
    logic signed [cic_dsp_pkg::ACC_WIDTH-1:0] acc_next [cic_dsp_pkg::STAGES];

    // single-cycle cascade of the next values
    always_comb
    begin
        acc_next[0] = acc[0] + pre_data;
        for (int i = 1; i < cic_dsp_pkg::STAGES; i++)
        begin
            acc_next[i] = acc[i] + acc_next[i-1];
        end
    end

    always_ff @(posedge clock)
    begin
        if (!rst_n || flush)
        begin
            for (int i = 0; i < cic_dsp_pkg::STAGES; i++)
            begin
                acc[i] <= '0;
            end
        end
        else if (pre_strobe)
        begin
            for (int i = 0; i < cic_dsp_pkg::STAGES; i++)
            begin
                acc[i] <= acc_next[i];
            end
        end
    end

    assign int_data = acc[cic_dsp_pkg::STAGES-1];

endmodule

// ==== hdl/cic_comb_chain.sv ====
// Four cascaded combs at the output rate, differential delay of one.
// The differences run combinationally on dec_strobe and the result
// is registered, so out_strobe trails dec_strobe by one cycle.
// Output is the top 16 bits, truncated. At ratio 1 the filter is
// bypassed and the prescaled input goes straight out.

`timescale 1ns/1ps

module cic_comb_chain (
    input  logic                                      clock,
    input  logic                                      rst_n,
    input  logic                                      flush,
    input  logic                                      dec_strobe,
    input  logic [cic_ctl_pkg::LOG2_WIDTH-1:0]        log2_decim,
    input  logic signed [cic_dsp_pkg::ACC_WIDTH-1:0]  int_data,
    input  logic signed [cic_dsp_pkg::ACC_WIDTH-1:0]  pre_data,
    output logic                                      out_strobe,
    output logic signed [cic_dsp_pkg::OUT_WIDTH-1:0]  out_data
);

    logic signed [cic_dsp_pkg::ACC_WIDTH-1:0] delay     [cic_dsp_pkg::STAGES];
    logic signed [cic_dsp_pkg::ACC_WIDTH-1:0] stage_in  [cic_dsp_pkg::STAGES];
    logic signed [cic_dsp_pkg::ACC_WIDTH-1:0] stage_out [cic_dsp_pkg::STAGES];

    // each stage subtracts its own input from the previous output period
    always_comb
    begin
        stage_in[0]  = int_data;
        stage_out[0] = stage_in[0] - delay[0];
        for (int i = 1; i < cic_dsp_pkg::STAGES; i++)
        begin
            stage_in[i]  = stage_out[i-1];
            stage_out[i] = stage_in[i] - delay[i];
        end
    end

    always_ff @(posedge clock)
    begin
        if (!rst_n || flush)
        begin
            for (int i = 0; i < cic_dsp_pkg::STAGES; i++)
            begin
                delay[i] <= '0;
            end
        end
        else if (dec_strobe)
        begin
            for (int i = 0; i < cic_dsp_pkg::STAGES; i++)
            begin
                delay[i] <= stage_in[i];
            end
        end
    end

    // output register, bypass selected at ratio 1
    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            out_strobe <= 1'b0;
            out_data   <= '0;
        end
        else
        begin
            out_strobe <= dec_strobe;
            if (dec_strobe)
            begin
                if (log2_decim == '0)
                    out_data <= pre_data[cic_dsp_pkg::ACC_WIDTH-1 -: cic_dsp_pkg::OUT_WIDTH];
                else
                    out_data <= stage_out[cic_dsp_pkg::STAGES-1]
                                [cic_dsp_pkg::ACC_WIDTH-1 -: cic_dsp_pkg::OUT_WIDTH];
            end
        end
    end

    // input spacing upstream keeps output strobes apart, even at ratio 1
    a_out_spacing: assert property (@(posedge clock) disable iff (!rst_n)
        out_strobe |=> !out_strobe);

endmodule

// ==== hdl/cic_decim_top.sv ====
// Four-stage CIC decimator, differential delay of one, ratio 1 to 64.
// Input strobes must be at least two cycles apart, and none may be
// sent while cfg_req is high. Output is truncated, never rounded,
// and has no back-pressure. Latency is 3 cycles from the input
// strobe that completes a group to out_strobe.

`timescale 1ns/1ps

module cic_decim_top (
    input  logic                                  clock,
    input  logic                                  rst_n,
    input  logic                                  cfg_req,
    input  logic [cic_ctl_pkg::LOG2_WIDTH-1:0]    cfg_log2_decim,
    output logic                                  cfg_ack,
    input  logic                                  in_strobe,
    input  logic signed [cic_dsp_pkg::IN_WIDTH-1:0]  in_data,
    output logic                                  out_strobe,
    output logic signed [cic_dsp_pkg::OUT_WIDTH-1:0] out_data
);

    logic [cic_ctl_pkg::LOG2_WIDTH-1:0]          log2_decim;
    logic                                        flush;
    logic                                        dec_strobe;
    logic                                        pre_strobe;
    logic signed [cic_dsp_pkg::ACC_WIDTH-1:0]    pre_data;
    logic signed [cic_dsp_pkg::ACC_WIDTH-1:0]    int_data;

    // config handshake and output-rate strobe
    cic_rate_control u_rate_control (
        .clock          (clock),
        .rst_n          (rst_n),
        .cfg_req        (cfg_req),
        .cfg_log2_decim (cfg_log2_decim),
        .pre_strobe     (pre_strobe),
        .cfg_ack        (cfg_ack),
        .log2_decim     (log2_decim),
        .flush          (flush),
        .dec_strobe     (dec_strobe)
    );

    cic_prescale u_prescale (
        .clock      (clock),
        .rst_n      (rst_n),
        .in_strobe  (in_strobe),
        .in_data    (in_data),
        .log2_decim (log2_decim),
        .pre_strobe (pre_strobe),
        .pre_data   (pre_data)
    );

    // input-rate half of the filter
    cic_integrator_chain u_integrator_chain (
        .clock      (clock),
        .rst_n      (rst_n),
        .flush      (flush),
        .pre_strobe (pre_strobe),
        .pre_data   (pre_data),
        .int_data   (int_data)
    );

    // output-rate half, with the ratio-1 bypass
    cic_comb_chain u_comb_chain (
        .clock      (clock),
        .rst_n      (rst_n),
        .flush      (flush),
        .dec_strobe (dec_strobe),
        .log2_decim (log2_decim),
        .int_data   (int_data),
        .pre_data   (pre_data),
        .out_strobe (out_strobe),
        .out_data   (out_data)
    );

endmodule

// ==== test/cic_checker.sv ====
// Scoreboard for the CIC decimator that watches only the top-level ports.
// Keeps a sample-by-sample model of the four-stage filter in 40-bit
// wrapping arithmetic and checks each output's value, its 3-cycle
// latency, the DC level once a constant run has settled, and cfg_ack.
// Assumes no input strobe is sent while cfg_req is high.

`timescale 1ns/1ps

module cic_checker (
    input  logic                                     clock,
    input  logic                                     rst_n,
    input  logic                                     cfg_req,
    input  logic [cic_ctl_pkg::LOG2_WIDTH-1:0]       cfg_log2_decim,
    input  logic                                     cfg_ack,
    input  logic                                     in_strobe,
    input  logic signed [cic_dsp_pkg::IN_WIDTH-1:0]  in_data,
    input  logic                                     out_strobe,
    input  logic signed [cic_dsp_pkg::OUT_WIDTH-1:0] out_data,
    output int                                       value_errors,
    output int                                       proto_errors,
    output int                                       pending
);

    logic signed [cic_dsp_pkg::ACC_WIDTH-1:0] integ  [cic_dsp_pkg::STAGES];
    logic signed [cic_dsp_pkg::ACC_WIDTH-1:0] comb_z [cic_dsp_pkg::STAGES];
    int                                       log2_ratio;
    int                                       in_count;
    int                                       run_len;
    logic signed [cic_dsp_pkg::IN_WIDTH-1:0]  last_in;
    logic                                     exp_ack;
    logic                                     rst_d;
    int                                       cycle;
    // expected outputs in order, with the DC level when the run has settled
    int                                       due_q [$];
    logic signed [cic_dsp_pkg::OUT_WIDTH-1:0] exp_q [$];
    bit                                       settled_q [$];
    logic signed [cic_dsp_pkg::OUT_WIDTH-1:0] dc_q [$];

    initial
    begin
        value_errors = 0;
        proto_errors = 0;
        pending      = 0;
        cycle        = 0;
        rst_d        = 1'b1;
        exp_ack      = 1'b0;
    end

    task automatic report_value(input string name, input logic signed [31:0] expected,
                                input logic signed [31:0] actual);
        $display("Fail at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        value_errors++;
    endtask

    task automatic clear_filter();
        for (int i = 0; i < cic_dsp_pkg::STAGES; i++)
        begin
            integ[i]  = '0;
            comb_z[i] = '0;
        end
        in_count = 0;
        run_len  = 0;
    endtask

    // one accepted input sample, and a predicted output at the end of a group
    task automatic model_sample(input logic signed [cic_dsp_pkg::IN_WIDTH-1:0] x);
        logic signed [cic_dsp_pkg::ACC_WIDTH-1:0] v;
        logic signed [cic_dsp_pkg::ACC_WIDTH-1:0] diff;
        int                                       ratio;
        int                                       shift;
        ratio = 1 << log2_ratio;
        shift = cic_dsp_pkg::STAGES * (int'(cic_ctl_pkg::LOG2_MAX_DECIM) - log2_ratio);
        v = x;
        v = v <<< shift;
        for (int i = 0; i < cic_dsp_pkg::STAGES; i++)
        begin
            integ[i] = integ[i] + v;
            v        = integ[i];
        end
        run_len = (run_len > 0 && x == last_in) ? run_len + 1 : 1;
        last_in = x;
        in_count++;
        if (in_count == ratio)
        begin
            in_count = 0;
            for (int i = 0; i < cic_dsp_pkg::STAGES; i++)
            begin
                diff      = v - comb_z[i];
                comb_z[i] = v;
                v         = diff;
            end
            due_q.push_back(cycle + 3);
            if (ratio == 1)
                exp_q.push_back(x);
            else
                exp_q.push_back(v[cic_dsp_pkg::ACC_WIDTH-1 -: cic_dsp_pkg::OUT_WIDTH]);
            settled_q.push_back(run_len >= cic_dsp_pkg::STAGES * ratio);
            dc_q.push_back(x);
        end
    endtask

    task automatic check_output();
        int                                       due;
        logic signed [cic_dsp_pkg::OUT_WIDTH-1:0] expected;
        bit                                       settled;
        logic signed [cic_dsp_pkg::OUT_WIDTH-1:0] dc;
        if (out_strobe)
        begin
            if (due_q.size() == 0)
            begin
                $display("Error at %0t: out_strobe came with no output expected", $time);
                proto_errors++;
            end
            else
            begin
                due      = due_q.pop_front();
                expected = exp_q.pop_front();
                settled  = settled_q.pop_front();
                dc       = dc_q.pop_front();
                if (due != cycle)
                begin
                    $display("Error at %0t: out_strobe came in cycle %0d, due in cycle %0d",
                             $time, cycle, due);
                    proto_errors++;
                end
                if (out_data !== expected)
                    report_value("out_data", expected, out_data);
                else if (settled && out_data !== dc)
                    report_value("out_data DC level", dc, out_data);
            end
        end
        else if (due_q.size() != 0 && due_q[0] < cycle)
        begin
            $display("Error at %0t: out_strobe missing, it was due in cycle %0d",
                     $time, due_q[0]);
            proto_errors++;
            due = due_q.pop_front();
            expected = exp_q.pop_front();
            settled = settled_q.pop_front();
            dc = dc_q.pop_front();
        end
    endtask

    always @(posedge clock)
    begin
        cycle++;
        if (!rst_d)
        begin
            // values left by the reset applied on the previous edge
            if (cfg_ack !== 1'b0)
                report_value("cfg_ack", 0, cfg_ack);
            if (out_strobe !== 1'b0)
                report_value("out_strobe", 0, out_strobe);
            if (out_data !== '0)
                report_value("out_data", 0, out_data);
        end
        else if (rst_n)
        begin
            if (cfg_ack !== exp_ack)
                report_value("cfg_ack", exp_ack, cfg_ack);
            check_output();
        end
        if (!rst_n)
        begin
            log2_ratio = 0;
            exp_ack    = 1'b0;
            clear_filter();
            due_q.delete();
            exp_q.delete();
            settled_q.delete();
            dc_q.delete();
        end
        else
        begin
            // four-phase port: take the value while req is high and ack low
            if (cfg_req && !exp_ack)
            begin
                if (cfg_log2_decim > cic_ctl_pkg::LOG2_MAX_DECIM)
                    log2_ratio = int'(cic_ctl_pkg::LOG2_MAX_DECIM);
                else
                    log2_ratio = int'(cfg_log2_decim);
                clear_filter();
                exp_ack = 1'b1;
            end
            else if (!cfg_req)
            begin
                exp_ack = 1'b0;
            end
            if (in_strobe)
                model_sample(in_data);
        end
        rst_d   = rst_n;
        pending = due_q.size();
    end

endmodule

// ==== test/tb_cic_decim.sv ====
// Testbench for the CIC decimator.
// Drives every input on the falling clock edge, with samples three
// cycles apart and none while a config load is in progress. Each row
// of the stimulus table loads a ratio and then sends constant or
// xorshift random samples. All comparing is done in cic_checker.

`timescale 1ns/1ps

module tb_cic_decim;

    localparam int ROWS        = 12;
    localparam int WAIT_LIMIT  = 50;
    localparam int DRAIN_LIMIT = 20;

    logic                                     clock;
    logic                                     rst_n;
    logic                                     cfg_req;
    logic [cic_ctl_pkg::LOG2_WIDTH-1:0]       cfg_log2_decim;
    logic                                     cfg_ack;
    logic                                     in_strobe;
    logic signed [cic_dsp_pkg::IN_WIDTH-1:0]  in_data;
    logic                                     out_strobe;
    logic signed [cic_dsp_pkg::OUT_WIDTH-1:0] out_data;
    int                                       value_errors;
    int                                       proto_errors;
    int                                       pending;
    int                                       timeout_errors;
    logic [31:0]                              rng_state;

    // stimulus table: ratio code, random or constant, constant value, sample count
    logic [cic_ctl_pkg::LOG2_WIDTH-1:0]       row_code   [ROWS];
    bit                                       row_random [ROWS];
    logic signed [cic_dsp_pkg::IN_WIDTH-1:0]  row_value  [ROWS];
    int                                       row_count  [ROWS];

    cic_decim_top DUT (
        .clock          (clock),
        .rst_n          (rst_n),
        .cfg_req        (cfg_req),
        .cfg_log2_decim (cfg_log2_decim),
        .cfg_ack        (cfg_ack),
        .in_strobe      (in_strobe),
        .in_data        (in_data),
        .out_strobe     (out_strobe),
        .out_data       (out_data)
    );

    cic_checker u_checker (
        .clock          (clock),
        .rst_n          (rst_n),
        .cfg_req        (cfg_req),
        .cfg_log2_decim (cfg_log2_decim),
        .cfg_ack        (cfg_ack),
        .in_strobe      (in_strobe),
        .in_data        (in_data),
        .out_strobe     (out_strobe),
        .out_data       (out_data),
        .value_errors   (value_errors),
        .proto_errors   (proto_errors),
        .pending        (pending)
    );

    initial
    begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic set_row(input int idx, input logic [2:0] code, input bit is_random,
                           input logic signed [15:0] value, input int count);
        row_code[idx]   = code;
        row_random[idx] = is_random;
        row_value[idx]  = value;
        row_count[idx]  = count;
    endtask

    task automatic send_sample(input logic signed [cic_dsp_pkg::IN_WIDTH-1:0] x);
        @(negedge clock);
        in_strobe = 1'b1;
        in_data   = x;
        @(negedge clock);
        in_strobe = 1'b0;
        @(negedge clock);
    endtask

    task automatic load_ratio(input logic [cic_ctl_pkg::LOG2_WIDTH-1:0] code);
        int waited;
        @(negedge clock);
        cfg_log2_decim = code;
        cfg_req        = 1'b1;
        waited = 0;
        while (cfg_ack !== 1'b1 && waited < WAIT_LIMIT)
        begin
            @(negedge clock);
            waited++;
        end
        if (cfg_ack !== 1'b1)
        begin
            $display("Timeout at %0t: cfg_ack never rose after cfg_req", $time);
            timeout_errors++;
        end
        cfg_req = 1'b0;
        waited  = 0;
        while (cfg_ack !== 1'b0 && waited < WAIT_LIMIT)
        begin
            @(negedge clock);
            waited++;
        end
        if (cfg_ack !== 1'b0)
        begin
            $display("Timeout at %0t: cfg_ack never fell after cfg_req dropped", $time);
            timeout_errors++;
        end
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (pending != 0 && waited < DRAIN_LIMIT)
        begin
            @(negedge clock);
            waited++;
        end
        if (pending != 0)
        begin
            $display("Timeout at %0t: %0d expected outputs never came", $time, pending);
            timeout_errors++;
        end
    endtask

    initial
    begin
        rst_n          = 1'b0;
        cfg_req        = 1'b0;
        cfg_log2_decim = '0;
        in_strobe      = 1'b0;
        in_data        = '0;
        timeout_errors = 0;
        rng_state      = 32'd25;
        set_row(0, 3'd1, 1'b0, 16'sd32767, 32);
        set_row(1, 3'd2, 1'b0, -16'sd32768, 64);
        set_row(2, 3'd3, 1'b0, 16'sd32767, 128);
        set_row(3, 3'd4, 1'b0, -16'sd32768, 256);
        set_row(4, 3'd5, 1'b0, 16'sd32767, 512);
        set_row(5, 3'd6, 1'b0, -16'sd32768, 640);
        // code 7 is clamped to ratio 64
        set_row(6, 3'd7, 1'b0, 16'sd20000, 640);
        // counts that stop mid-group, so the next load flushes a partial sum
        set_row(7, 3'd2, 1'b1, 16'sd0, 202);
        set_row(8, 3'd6, 1'b1, 16'sd0, 650);
        set_row(9, 3'd0, 1'b0, -16'sd1234, 16);
        set_row(10, 3'd4, 1'b1, 16'sd0, 90);
        set_row(11, 3'd3, 1'b0, 16'sd32767, 64);
        // ten rising edges with reset low, released on the next falling edge
        repeat (10) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        // ratio 1 straight out of reset, no load
        for (int i = 0; i < 12; i++)
        begin
            rng_state = xorshift32(rng_state);
            send_sample(rng_state[15:0]);
        end
        for (int r = 0; r < ROWS; r++)
        begin
            load_ratio(row_code[r]);
            for (int n = 0; n < row_count[r]; n++)
            begin
                if (row_random[r])
                begin
                    rng_state = xorshift32(rng_state);
                    send_sample(rng_state[15:0]);
                end
                else
                begin
                    send_sample(row_value[r]);
                end
            end
        end
        wait_for_drain();
        // idle cycles to catch a stray out_strobe
        repeat (8) @(negedge clock);
        $display("value errors %0d, protocol errors %0d, timeouts %0d",
                 value_errors, proto_errors, timeout_errors);
        if (value_errors + proto_errors + timeout_errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== all.f ====
hdl/cic_dsp_pkg.sv
hdl/cic_ctl_pkg.sv
hdl/cic_rate_control.sv
hdl/cic_prescale.sv
hdl/cic_integrator_chain.sv
hdl/cic_comb_chain.sv
hdl/cic_decim_top.sv
test/cic_checker.sv
test/tb_cic_decim.sv
